// ==== design/fft_pkg.sv ====
`default_nettype none

package fft_pkg;

   localparam int n_points  = 16;
   localparam int radix     = 4;
   localparam int data_w    = 11;
   localparam int coef_w    = 11;
   localparam int coef_frac = 9;  // 512 is unity
   localparam int n_tw      = 10; // exponents 0..9 reach tw_base*m

   typedef logic signed [data_w-1:0] data_t;
   typedef logic signed [coef_w-1:0] coef_t;
   typedef logic [$clog2(n_points)-1:0] idx_t;

   typedef struct packed {
      data_t re;
      data_t im;
   } sample_t;

   typedef sample_t [radix-1:0] quad_t;
   typedef idx_t [radix-1:0] quad_idx_t;
   typedef sample_t [n_points-1:0] frame_t;

   // cos(2*pi*p/16) scaled by 512
   localparam coef_t twiddle_re [n_tw] = '{
      11'sd512,
      11'sd473,
      11'sd362,
      11'sd196,
      11'sd0,
      -11'sd196,
      -11'sd362,
      -11'sd473,
      -11'sd512,
      -11'sd473
   };

   // -sin(2*pi*p/16) scaled by 512
   localparam coef_t twiddle_im [n_tw] = '{
      11'sd0,
      -11'sd196,
      -11'sd362,
      -11'sd473,
      -11'sd512,
      -11'sd473,
      -11'sd362,
      -11'sd196,
      11'sd0,
      11'sd196
   };

endpackage

`default_nettype wire

// ==== design/fft_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module fft_sequencer import fft_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       start,
   input  logic       bf_done,
   output logic       load,
   output quad_idx_t  idx,
   output logic [1:0] tw_base,
   output logic       bf_start,
   output logic       wr_en,
   output logic       valid
);

   typedef enum logic [1:0] {
      idle,
      stage_1,
      stage_2,
      finish
   } state_t;

   state_t     state;
   logic [1:0] cnt;     // butterfly within stage
   logic       waiting; // butterfly in flight
   logic       busy;

   assign busy = (state == stage_1) || (state == stage_2);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state   <= idle;
         cnt     <= '0;
         waiting <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (start) begin
                  state   <= stage_1;
                  cnt     <= '0;
                  waiting <= 1'b0;
               end
            end
            stage_1, stage_2: begin
               if (!waiting) begin
                  waiting <= 1'b1;
               end else if (bf_done) begin
                  waiting <= 1'b0;
                  cnt     <= cnt + 2'd1; // wraps to 0 after the fourth
                  if (cnt == 2'd3) begin
                     state <= (state == stage_1) ? stage_2 : finish;
                  end
               end
            end
            finish: begin
               state <= idle;
            end
            default: begin
               state <= idle;
            end
         endcase
      end
   end

   // stage 1 strides by 4, stage 2 takes consecutive groups
   always_comb begin
      for (int m = 0; m < radix; m++) begin
         if (state == stage_1) begin
            idx[m] = idx_t'(radix * m + cnt);
         end else begin
            idx[m] = idx_t'(radix * cnt + m);
         end
      end
   end

   assign tw_base  = (state == stage_1) ? cnt : 2'd0; // no twiddle in last stage
   assign load     = (state == idle) && start;
   assign bf_start = busy && !waiting;
   assign wr_en    = busy && waiting && bf_done;
   assign valid    = (state == finish);

endmodule

`default_nettype wire

// ==== design/sample_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_store import fft_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      load,
   input  frame_t    x,
   input  quad_idx_t idx,
   input  logic      wr_en,
   input  quad_t     wr_data,
   output quad_t     rd_data,
   output frame_t    contents
);

   frame_t mem;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mem <= '0;
      end else if (load) begin
         mem <= x; // whole frame at once
      end else if (wr_en) begin
         for (int m = 0; m < radix; m++) begin
            mem[idx[m]] <= wr_data[m]; // in place
         end
      end
   end

   always_comb begin
      for (int m = 0; m < radix; m++) begin
         rd_data[m] = mem[idx[m]];
      end
   end

   assign contents = mem;

endmodule

`default_nettype wire

// ==== design/radix4_butterfly.sv ====
`timescale 1ns/10ps
`default_nettype none

module radix4_butterfly import fft_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       start,
   input  quad_t      a,
   input  logic [1:0] tw_base,
   output logic       done,
   output quad_t      b
);

   typedef logic signed [data_w+1:0] sum_t;         // four-term sum
   typedef logic signed [data_w+coef_w:0] prod_t;   // complex product part
   typedef logic [$clog2(n_tw)-1:0] tw_idx_t;

   sum_t       sum_re [radix];
   sum_t       sum_im [radix];
   quad_t      scaled;
   quad_t      scaled_q;
   logic [1:0] tw_q;
   quad_t      rotated;
   logic [1:0] vld;

   // radix-4 network, j terms swap re and im
   always_comb begin
      sum_re[0] = sum_t'(a[0].re) + a[1].re + a[2].re + a[3].re;
      sum_im[0] = sum_t'(a[0].im) + a[1].im + a[2].im + a[3].im;
      sum_re[1] = sum_t'(a[0].re) + a[1].im - a[2].re - a[3].im;
      sum_im[1] = sum_t'(a[0].im) - a[1].re - a[2].im + a[3].re;
      sum_re[2] = sum_t'(a[0].re) - a[1].re + a[2].re - a[3].re;
      sum_im[2] = sum_t'(a[0].im) - a[1].im + a[2].im - a[3].im;
      sum_re[3] = sum_t'(a[0].re) - a[1].im - a[2].re + a[3].im;
      sum_im[3] = sum_t'(a[0].im) + a[1].re - a[2].im - a[3].re;
      for (int m = 0; m < radix; m++) begin
         scaled[m].re = data_t'(sum_re[m] >>> 2); // divide by 4
         scaled[m].im = data_t'(sum_im[m] >>> 2);
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         scaled_q <= scaled;
         tw_q     <= tw_base;
      end
   end

   // output m rotated by W^(tw_base*m)
   always_comb begin
      tw_idx_t p;
      coef_t   wr;
      coef_t   wi;
      prod_t   pr;
      prod_t   pi;
      for (int m = 0; m < radix; m++) begin
         p  = tw_idx_t'(tw_q * m);
         wr = twiddle_re[p];
         wi = twiddle_im[p];
         pr = prod_t'(scaled_q[m].re) * wr - prod_t'(scaled_q[m].im) * wi;
         pi = prod_t'(scaled_q[m].re) * wi + prod_t'(scaled_q[m].im) * wr;
         rotated[m].re = data_t'(pr >>> coef_frac); // wraps on overflow
         rotated[m].im = data_t'(pi >>> coef_frac);
      end
   end

   always_ff @(posedge clk) begin
      if (vld[0]) begin
         b <= rotated;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         vld <= '0;
      end else begin
         vld <= {vld[0], start};
      end
   end

   assign done = vld[1];

endmodule

`default_nettype wire

// ==== design/fft16_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module fft16_top import fft_pkg::*; (
   input  logic   clk,
   input  logic   rst,
   input  logic   start,
   input  frame_t x,
   output frame_t y,
   output logic   valid
);

   logic      load;
   logic      bf_start;
   logic      bf_done;
   logic      wr_en;
   logic [1:0] tw_base;
   quad_idx_t idx;
   quad_t     rd_data;
   quad_t     bf_result;
   frame_t    contents;

   fft_sequencer u_seq (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .bf_done  (bf_done),
      .load     (load),
      .idx      (idx),
      .tw_base  (tw_base),
      .bf_start (bf_start),
      .wr_en    (wr_en),
      .valid    (valid)
   );

   sample_store u_store (
      .clk      (clk),
      .rst      (rst),
      .load     (load),
      .x        (x),
      .idx      (idx),
      .wr_en    (wr_en),
      .wr_data  (bf_result),
      .rd_data  (rd_data),
      .contents (contents)
   );

   radix4_butterfly u_bf (
      .clk     (clk),
      .rst     (rst),
      .start   (bf_start),
      .a       (rd_data),
      .tw_base (tw_base),
      .done    (bf_done),
      .b       (bf_result)
   );

   // base-4 digit reversal of the output index
   always_comb begin
      for (int k = 0; k < n_points; k++) begin
         y[k] = contents[radix * (k % radix) + k / radix];
      end
   end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk; // 100 ns period
   end

   initial begin
      rst = 1'b0;
      repeat (8) @(negedge clk);
      rst = 1'b1; // released away from the rising edge
   end

endmodule

`default_nettype wire

// ==== verification/tb_fft16.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_fft16 import fft_pkg::*; ();

   logic        clk;
   logic        rst;
   logic        start;
   frame_t      x;
   frame_t      y;
   logic        valid;
   int unsigned lcg_state = 59029;

   tb_clock_gen u_clk (.clk(clk), .rst(rst));

   fft16_top i_dut (.clk(clk), .rst(rst), .start(start), .x(x), .y(y), .valid(valid));

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_sample(input sample_t got, input sample_t exp, input int k);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch at %0t: y[%0d] is (%0d, %0d), expected (%0d, %0d)",
            $time, k, got.re, got.im, exp.re, exp.im));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_failure($sformatf("Mismatch at %0t: %s, valid is %b, expected %b",
            $time, what, got, exp));
      end
   endtask

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic frame_t random_frame();
      frame_t f;
      for (int k = 0; k < n_points; k++) begin
         f[k].re = data_t'(lcg_next() >> 21); // upper bits, full range
         f[k].im = data_t'(lcg_next() >> 21);
      end
      return f;
   endfunction

   // every stride group drives s1 to full scale
   function automatic frame_t wrap_frame();
      frame_t f;
      for (int k = 0; k < n_points; k++) begin
         f[k].re = (k / radix == 0 || k / radix == 3) ? data_t'(1023) : data_t'(-1024);
         f[k].im = (k / radix < 2) ? data_t'(1023) : data_t'(-1024);
      end
      return f;
   endfunction

   function automatic quad_t butterfly_model(input quad_t a, input int base);
      int    ar [4];
      int    ai [4];
      int    sr [4];
      int    si [4];
      int    p;
      int    prod_re;
      int    prod_im;
      quad_t r;
      for (int m = 0; m < radix; m++) begin
         ar[m] = a[m].re;
         ai[m] = a[m].im;
      end
      sr[0] = ar[0] + ar[1] + ar[2] + ar[3];
      si[0] = ai[0] + ai[1] + ai[2] + ai[3];
      sr[1] = ar[0] + ai[1] - ar[2] - ai[3]; // -j*a1 brings im into re
      si[1] = ai[0] - ar[1] - ai[2] + ar[3];
      sr[2] = ar[0] - ar[1] + ar[2] - ar[3];
      si[2] = ai[0] - ai[1] + ai[2] - ai[3];
      sr[3] = ar[0] - ai[1] - ar[2] + ai[3];
      si[3] = ai[0] + ar[1] - ai[2] - ar[3];
      for (int m = 0; m < radix; m++) begin
         p       = base * m;
         prod_re = (sr[m] >>> 2) * twiddle_re[p] - (si[m] >>> 2) * twiddle_im[p];
         prod_im = (sr[m] >>> 2) * twiddle_im[p] + (si[m] >>> 2) * twiddle_re[p];
         r[m].re = data_t'(prod_re >>> coef_frac); // keeps low bits only
         r[m].im = data_t'(prod_im >>> coef_frac);
      end
      return r;
   endfunction

   function automatic frame_t fft_model(input frame_t in);
      frame_t    st;
      frame_t    out;
      quad_idx_t pos;
      quad_t     q;
      st = in;
      for (int stage = 0; stage < 2; stage++) begin
         for (int g = 0; g < radix; g++) begin
            for (int m = 0; m < radix; m++) begin
               pos[m] = (stage == 0) ? idx_t'(g + radix * m) : idx_t'(radix * g + m);
               q[m]   = st[pos[m]];
            end
            q = butterfly_model(q, (stage == 0) ? g : 0);
            for (int m = 0; m < radix; m++) begin
               st[pos[m]] = q[m];
            end
         end
      end
      for (int k = 0; k < n_points; k++) begin
         out[k] = st[radix * (k % radix) + k / radix]; // digit reversal
      end
      return out;
   endfunction

   task automatic check_frame(input frame_t exp);
      for (int k = 0; k < n_points; k++) begin
         check_sample(y[k], exp[k], k);
      end
   endtask

   // called right after a falling edge
   task automatic pulse_start(input frame_t f);
      x     = f;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
   endtask

   task automatic wait_valid();
      int cycles;
      cycles = 0;
      while (valid !== 1'b1) begin
         if (cycles == 100) begin
            report_failure("valid pulse did not arrive within 100 cycles");
         end
         @(negedge clk);
         cycles++;
      end
   endtask

   task automatic run_and_check(input frame_t f);
      @(negedge clk);
      pulse_start(f);
      wait_valid();
      check_frame(fft_model(f));
      @(negedge clk);
      check_bit(valid, 1'b0, "valid longer than one cycle");
   endtask

   task automatic test_idle_after_reset();
      repeat (20) begin
         @(negedge clk);
         check_bit(valid, 1'b0, "valid without start");
      end
   endtask

   task automatic test_impulse();
      frame_t f;
      f       = '0;
      f[0].re = data_t'(400);
      f[0].im = data_t'(-300);
      run_and_check(f);
   endtask

   task automatic test_patterns();
      frame_t f;
      for (int k = 0; k < n_points; k++) begin
         f[k].re = data_t'(300);
         f[k].im = data_t'(-200);
      end
      run_and_check(f); // only bin 0 nonzero
      for (int k = 0; k < n_points; k++) begin
         f[k].re = (k % 2) ? data_t'(-500) : data_t'(500);
         f[k].im = (k % 2) ? data_t'(250) : data_t'(-250);
      end
      run_and_check(f);
   endtask

   task automatic test_random_frames();
      run_and_check(wrap_frame()); // rotated parts overflow
      repeat (10) begin
         run_and_check(random_frame());
      end
   endtask

   task automatic test_start_while_busy();
      frame_t fa;
      frame_t fb;
      frame_t exp;
      fa  = random_frame();
      fb  = random_frame();
      exp = fft_model(fa);
      @(negedge clk);
      pulse_start(fa);
      repeat (5) @(negedge clk);
      pulse_start(fb); // mid-frame, must be dropped
      wait_valid();
      check_frame(exp);
      repeat (40) begin
         @(negedge clk);
         check_bit(valid, 1'b0, "second valid pulse after ignored start");
         check_frame(exp);
      end
   endtask

   task automatic test_back_to_back();
      frame_t fa;
      frame_t fb;
      fa = random_frame();
      fb = random_frame();
      @(negedge clk);
      pulse_start(fa);
      wait_valid();
      check_frame(fft_model(fa));
      @(negedge clk);
      check_bit(valid, 1'b0, "valid longer than one cycle");
      pulse_start(fb); // first idle cycle
      wait_valid();
      check_frame(fft_model(fb));
   endtask

   initial begin
      start = 1'b0;
      x     = '0;
      wait (rst === 1'b1);
      test_idle_after_reset();
      test_impulse();
      test_patterns();
      test_random_frames();
      test_start_while_busy();
      test_back_to_back();
      @(negedge clk);
      $display("Result: PASSED");
      $finish;
   end

   initial begin : watchdog
      int limit;
      limit = 17 * 200; // 17 frames, 200 cycles each
      repeat (limit) @(posedge clk);
      report_failure("simulation timed out before all tests finished");
   end

endmodule

`default_nettype wire

// ==== fft16_top.f ====
design/fft_pkg.sv
design/fft_sequencer.sv
design/sample_store.sv
design/radix4_butterfly.sv
design/fft16_top.sv
verification/tb_clock_gen.sv
verification/tb_fft16.sv

// ==== Bender.yml ====
package:
  name: fft16

sources:
  - design/fft_pkg.sv
  - design/fft_sequencer.sv
  - design/sample_store.sv
  - design/radix4_butterfly.sv
  - design/fft16_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_fft16.sv
